/* sigmoid_pkg.sv */
`default_nettype none

package sigmoid_pkg;

    localparam int DATA_BIT    = 16;
    localparam int ALPHA_FRAC  = 15;
    localparam int PRODUCT_BIT = 32;
    localparam int NUM_SEG     = 15;
    localparam int PIPE_DEPTH  = 3;

    typedef logic signed [DATA_BIT-1:0] sample_t;

    // Q10 fixed point
    localparam sample_t ONE_Q10 = 16'sh0400;

    // upper breakpoint of segments 0 to 13, ascending
    localparam sample_t SEG_BREAK [0:NUM_SEG-2] = '{
        16'shE000,
        16'shEE00,
        16'shF400,
        16'shF600,
        16'shF800,
        16'shFA00,
        16'shFC00,
        16'sh0400,
        16'sh0600,
        16'sh0800,
        16'sh0A00,
        16'sh0C00,
        16'sh1200,
        16'sh2000
    };

    // flat at both ends
    localparam sample_t SEG_ALPHA [0:NUM_SEG-1] = '{
        16'sh0000,
        16'sh0050,
        16'sh0317,
        16'sh082D,
        16'sh0AA2,
        16'sh107F,
        16'sh14ED,
        16'sh1E4D,
        16'sh14ED,
        16'sh107F,
        16'sh0AA2,
        16'sh082D,
        16'sh0317,
        16'sh0050,
        16'sh0000
    };

    // top segment saturates at 1.0
    localparam sample_t SEG_BIAS [0:NUM_SEG-1] = '{
        16'sh0000,
        16'sh0012,
        16'sh0076,
        16'sh00F0,
        16'sh0122,
        16'sh017F,
        16'sh01B5,
        16'sh0200,
        16'sh024A,
        16'sh0280,
        16'sh02DD,
        16'sh030F,
        16'sh0389,
        16'sh03ED,
        ONE_Q10
    };

    // APB register map
    localparam logic [11:0] ADDR_DATA_IN  = 12'h000;
    localparam logic [11:0] ADDR_DATA_OUT = 12'h004;
    localparam logic [11:0] ADDR_STATUS   = 12'h008;

endpackage

`default_nettype wire

/* sigmoid_segment_lookup.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid_segment_lookup (
    input  wire                   M_AXI_ACLK,
    input  wire                   rst,
    input  wire                   in_valid,
    input  wire sigmoid_pkg::sample_t in_sample,
    output logic                  seg_valid,
    output sigmoid_pkg::sample_t  seg_sample,
    output sigmoid_pkg::sample_t  seg_alpha,
    output sigmoid_pkg::sample_t  seg_bias
);

    localparam int IDX_BIT = $clog2(sigmoid_pkg::NUM_SEG);

    logic [sigmoid_pkg::NUM_SEG-2:0] hit;
    logic [IDX_BIT-1:0]              seg_idx;

    // all breakpoints compared at once, signed
    always_comb begin
        for (int k = 0; k < sigmoid_pkg::NUM_SEG - 1; k++) begin
            hit[k] = (in_sample <= sigmoid_pkg::SEG_BREAK[k]);
        end
    end

    // lowest matching segment wins, else top segment
    always_comb begin
        seg_idx = IDX_BIT'(sigmoid_pkg::NUM_SEG - 1);
        for (int k = sigmoid_pkg::NUM_SEG - 2; k >= 0; k--) begin
            if (hit[k]) begin
                seg_idx = IDX_BIT'(k);
            end
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= in_valid;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        seg_sample <= in_sample;
        seg_alpha  <= sigmoid_pkg::SEG_ALPHA[seg_idx];
        seg_bias   <= sigmoid_pkg::SEG_BIAS[seg_idx];
    end

endmodule

`default_nettype wire

/* sigmoid_mac.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid_mac (
    input  wire                   M_AXI_ACLK,
    input  wire                   rst,
    input  wire                   seg_valid,
    input  wire sigmoid_pkg::sample_t seg_sample,
    input  wire sigmoid_pkg::sample_t seg_alpha,
    input  wire sigmoid_pkg::sample_t seg_bias,
    output logic                  out_valid,
    output sigmoid_pkg::sample_t  out_result
);

    logic signed [sigmoid_pkg::PRODUCT_BIT-1:0] product;
    logic signed [sigmoid_pkg::PRODUCT_BIT-1:0] product_scaled;
    logic                                       mul_valid;
    sigmoid_pkg::sample_t                       mul_q;
    sigmoid_pkg::sample_t                       bias_q;

    // full-width signed product, then drop the slope fraction
    assign product        = seg_alpha * seg_sample;
    assign product_scaled = product >>> sigmoid_pkg::ALPHA_FRAC;

    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            mul_valid <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            mul_valid <= seg_valid;
            out_valid <= mul_valid;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        mul_q  <= product_scaled[sigmoid_pkg::DATA_BIT-1:0];
        bias_q <= seg_bias;
        // wraps at 16 bits
        out_result <= mul_q + bias_q;
    end

endmodule

`default_nettype wire

/* sigmoid_result_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid_result_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                            M_AXI_ACLK,
    input  wire                            rst,
    input  wire                            wr_en,
    input  wire sigmoid_pkg::sample_t      wr_data,
    input  wire                            rd_en,
    output sigmoid_pkg::sample_t           rd_data,
    output logic                           empty,
    output logic [$clog2(FIFO_DEPTH):0]    count
);

    localparam int PTR_BIT = $clog2(FIFO_DEPTH);

    sigmoid_pkg::sample_t mem [0:FIFO_DEPTH-1];
    logic [PTR_BIT-1:0]   wr_ptr;
    logic [PTR_BIT-1:0]   rd_ptr;
    logic                 full;
    logic                 do_wr;
    logic                 do_rd;

    assign empty = (count == '0);
    assign full  = (count == (PTR_BIT + 1)'(FIFO_DEPTH));
    assign do_rd = rd_en && !empty;
    // a pop in the same cycle frees the slot
    assign do_wr = wr_en && (!full || do_rd);

    // first-word fall-through
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge M_AXI_ACLK) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sigmoid_apb_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid_apb_slave #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire                            M_AXI_ACLK,
    input  wire                            rst,
    input  wire                            psel,
    input  wire                            penable,
    input  wire                            pwrite,
    input  wire [11:0]                     paddr,
    input  wire [31:0]                     pwdata,
    input  wire sigmoid_pkg::sample_t      rd_data,
    input  wire                            empty,
    input  wire [$clog2(FIFO_DEPTH):0]     count,
    output logic [31:0]                    prdata,
    output logic                           pready,
    output logic                           pslverr,
    output logic                           in_valid,
    output sigmoid_pkg::sample_t           in_sample,
    output logic                           rd_en
);

    localparam int CNT_BIT = $clog2(FIFO_DEPTH) + 1;
    localparam int PD      = sigmoid_pkg::PIPE_DEPTH;

    logic               access;
    logic               wr_access;
    logic               rd_access;
    logic               sel_in;
    logic               sel_out;
    logic               sel_status;
    logic               room;
    logic               err;
    logic [CNT_BIT-1:0] in_flight;
    logic [CNT_BIT:0]   occupancy;
    logic [PD-1:0]      admit_sr;

    assign sel_in     = (paddr == sigmoid_pkg::ADDR_DATA_IN);
    assign sel_out    = (paddr == sigmoid_pkg::ADDR_DATA_OUT);
    assign sel_status = (paddr == sigmoid_pkg::ADDR_STATUS);

    assign access    = psel && penable;
    assign wr_access = access && pwrite;
    assign rd_access = access && !pwrite;

    // results already queued plus those still in the pipeline
    assign occupancy = {1'b0, count} + {1'b0, in_flight};
    assign room      = (occupancy < (CNT_BIT + 1)'(FIFO_DEPTH));

    // hold off input writes until the FIFO can take the result
    assign pready = !(psel && pwrite && sel_in) || room;

    assign err = (wr_access && !sel_in)
              || (rd_access && !(sel_out || sel_status))
              || (rd_access && sel_out && empty);
    assign pslverr = err;

    assign in_valid  = wr_access && sel_in && room;
    assign in_sample = pwdata[sigmoid_pkg::DATA_BIT-1:0];

    assign rd_en = rd_access && sel_out && !empty;

    always_comb begin
        prdata = '0;
        if (rd_access && sel_out && !empty) begin
            prdata = {{(32 - sigmoid_pkg::DATA_BIT){rd_data[sigmoid_pkg::DATA_BIT-1]}},
                      rd_data};
        end else if (rd_access && sel_status) begin
            prdata = {{(32 - CNT_BIT){1'b0}}, count};
        end
    end

    // admission pulse leaves the pipeline PIPE_DEPTH cycles later
    always_ff @(posedge M_AXI_ACLK) begin
        if (rst) begin
            admit_sr  <= '0;
            in_flight <= '0;
        end else begin
            admit_sr <= {admit_sr[PD-2:0], in_valid};
            case ({in_valid, admit_sr[PD-1]})
                2'b10:   in_flight <= in_flight + 1'b1;
                2'b01:   in_flight <= in_flight - 1'b1;
                default: in_flight <= in_flight;
            endcase
        end
    end

endmodule

`default_nettype wire

/* sigmoid_top.sv */
`timescale 1ns/10ps
`default_nettype none

module sigmoid_top #(
    parameter int FIFO_DEPTH = 8
) (
    input  wire         M_AXI_ACLK,
    input  wire         rst,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire [11:0]  paddr,
    input  wire [31:0]  pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int CNT_BIT = $clog2(FIFO_DEPTH) + 1;

    // slave to pipeline
    logic                 in_valid;
    sigmoid_pkg::sample_t in_sample;

    // lookup to mac
    logic                 seg_valid;
    sigmoid_pkg::sample_t seg_sample;
    sigmoid_pkg::sample_t seg_alpha;
    sigmoid_pkg::sample_t seg_bias;

    // mac to FIFO
    logic                 out_valid;
    sigmoid_pkg::sample_t out_result;

    // FIFO to slave
    logic                 rd_en;
    sigmoid_pkg::sample_t rd_data;
    logic                 empty;
    logic [CNT_BIT-1:0]   count;

    sigmoid_apb_slave #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_apb_slave (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .rd_data   (rd_data),
        .empty     (empty),
        .count     (count),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .rd_en     (rd_en)
    );

    sigmoid_segment_lookup u_lookup (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_sample (in_sample),
        .seg_valid (seg_valid),
        .seg_sample(seg_sample),
        .seg_alpha (seg_alpha),
        .seg_bias  (seg_bias)
    );

    sigmoid_mac u_mac (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .seg_valid (seg_valid),
        .seg_sample(seg_sample),
        .seg_alpha (seg_alpha),
        .seg_bias  (seg_bias),
        .out_valid (out_valid),
        .out_result(out_result)
    );

    sigmoid_result_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_result_fifo (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .wr_en     (out_valid),
        .wr_data   (out_result),
        .rd_en     (rd_en),
        .rd_data   (rd_data),
        .empty     (empty),
        .count     (count)
    );

endmodule

`default_nettype wire

/* tb_sigmoid.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_sigmoid;

    localparam int FIFO_DEPTH   = 8;
    localparam int WAIT_LIMIT   = 50;
    localparam int RANDOM_COUNT = 200;
    // roughly 1800 cycles of traffic, doubled for margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic        M_AXI_ACLK;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    sigmoid_pkg::sample_t exp_q[$];
    logic [31:0]          got_q[$];
    event                 got_ev;
    int                   pending;
    int                   compared;
    int                   cycle_count;
    logic [31:0]          cmp_actual;
    sigmoid_pkg::sample_t cmp_sample;
    sigmoid_pkg::sample_t cmp_expect;

    sigmoid_top dut0 (
        .M_AXI_ACLK(M_AXI_ACLK),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr)
    );

    always #2 M_AXI_ACLK = ~M_AXI_ACLK;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Finished with errors");
        $fatal(1, "simulation stopped on first error");
    endtask

    // segment search, then scaled slope times sample plus intercept
    function automatic sigmoid_pkg::sample_t sigmoid_ref(input sigmoid_pkg::sample_t x);
        int     seg;
        longint prod;
        seg = sigmoid_pkg::NUM_SEG - 1;
        for (int k = 0; k < sigmoid_pkg::NUM_SEG - 1; k++) begin
            if (x <= sigmoid_pkg::SEG_BREAK[k]) begin
                seg = k;
                break;
            end
        end
        prod = longint'(sigmoid_pkg::SEG_ALPHA[seg]) * longint'(x);
        prod = prod >>> sigmoid_pkg::ALPHA_FRAC;
        return sigmoid_pkg::sample_t'(16'(prod) + sigmoid_pkg::SEG_BIAS[seg]);
    endfunction

    // half full range, half around the sloped segments
    function automatic sigmoid_pkg::sample_t random_sample();
        int v;
        if ($urandom % 2) begin
            v = $urandom;
        end else begin
            v = int'($urandom % 32'h4800) - 32'h2400;
        end
        return sigmoid_pkg::sample_t'(v);
    endfunction

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input int max_wait, input logic keep_sel,
                             output logic done, output logic err);
        int waited;
        waited = 0;
        done = 1'b0;
        err = 1'b0;
        @(negedge M_AXI_ACLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge M_AXI_ACLK);
        penable = 1'b1;
        #1;
        while (!pready && waited < max_wait) begin
            @(negedge M_AXI_ACLK);
            #1;
            waited++;
        end
        if (pready) begin
            done = 1'b1;
            err  = pslverr;
            if (addr == sigmoid_pkg::ADDR_DATA_IN && !pslverr) begin
                exp_q.push_back(sigmoid_pkg::sample_t'(data[15:0]));
                pending++;
            end
        end
        // a write that never got pready is abandoned here
        if (!(done && keep_sel)) begin
            @(negedge M_AXI_ACLK);
            psel    = 1'b0;
            penable = 1'b0;
            pwrite  = 1'b0;
        end
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        @(negedge M_AXI_ACLK);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge M_AXI_ACLK);
        penable = 1'b1;
        #1;
        assert (pready) else stop_with_error("read did not complete in its access cycle");
        data = prdata;
        err  = pslverr;
        if (addr == sigmoid_pkg::ADDR_DATA_OUT && !pslverr) begin
            got_q.push_back(prdata);
            pending--;
            -> got_ev;
        end
        @(negedge M_AXI_ACLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic push_sample(input sigmoid_pkg::sample_t x);
        logic done;
        logic err;
        apb_write(sigmoid_pkg::ADDR_DATA_IN, {{16{x[15]}}, x}, WAIT_LIMIT, 1'b0, done, err);
        assert (done && !err) else stop_with_error("input sample write was not accepted");
    endtask

    task automatic wait_status(input int n);
        logic [31:0] data;
        logic        err;
        for (int i = 0; i < WAIT_LIMIT; i++) begin
            apb_read(sigmoid_pkg::ADDR_STATUS, data, err);
            assert (!err) else stop_with_error("status read returned a slave error");
            if (data == n) begin
                break;
            end
        end
        assert (data == n) else stop_with_error($sformatf(
            "[FAIL] %0t: status expected %0d got %0d", $time, n, data));
    endtask

    // pop everything outstanding, then confirm the FIFO reports empty
    task automatic drain_all();
        logic [31:0] data;
        logic        err;
        int          n;
        wait_status(pending);
        n = pending;
        repeat (n) begin
            apb_read(sigmoid_pkg::ADDR_DATA_OUT, data, err);
            assert (!err) else stop_with_error("pop of a queued result returned a slave error");
        end
        apb_read(sigmoid_pkg::ADDR_DATA_OUT, data, err);
        assert (err && data == 0) else stop_with_error($sformatf(
            "[FAIL] %0t: empty pop expected error and 0, got err %b data %h", $time, err, data));
    endtask

    always begin
        @(got_ev);
        while (got_q.size() > 0) begin
            cmp_actual = got_q.pop_front();
            assert (exp_q.size() > 0) else stop_with_error(
                "a result was read with no sample written");
            cmp_sample = exp_q.pop_front();
            cmp_expect = sigmoid_ref(cmp_sample);
            assert (cmp_actual == {{16{cmp_expect[15]}}, cmp_expect}) else stop_with_error(
                $sformatf("[FAIL] %0t: sample %h expected %h got %h",
                          $time, cmp_sample, cmp_expect, cmp_actual));
            compared++;
        end
    end

    always @(posedge M_AXI_ACLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("run timed out after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    initial begin
        sigmoid_pkg::sample_t vec[$];
        sigmoid_pkg::sample_t x;
        logic [31:0]          rdata;
        logic                 rerr;
        logic                 done;
        int                   written;
        int                   base_count;
        M_AXI_ACLK  = 1'b0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        pending     = 0;
        compared    = 0;
        cycle_count = 0;
        void'($urandom(85));
        repeat (5) @(posedge M_AXI_ACLK);
        @(negedge M_AXI_ACLK);
        rst = 1'b0;

        // reset state
        apb_read(sigmoid_pkg::ADDR_STATUS, rdata, rerr);
        assert (!rerr && rdata == 0) else stop_with_error($sformatf(
            "[FAIL] %0t: status after reset expected 0 got %h", $time, rdata));
        apb_read(sigmoid_pkg::ADDR_DATA_OUT, rdata, rerr);
        assert (rerr && rdata == 0) else stop_with_error($sformatf(
            "[FAIL] %0t: pop after reset expected error and 0, got %h", $time, rdata));

        // breakpoints, their neighbours and both saturation ends
        assert (sigmoid_ref(16'sh0000) == 16'sh0200) else stop_with_error(
            "reference model gives the wrong value at zero");
        assert (sigmoid_ref(16'sh8000) == 16'sh0000) else stop_with_error(
            "reference model gives the wrong low saturation value");
        assert (sigmoid_ref(16'sh7FFF) == sigmoid_pkg::ONE_Q10) else stop_with_error(
            "reference model gives the wrong high saturation value");
        for (int k = 0; k < sigmoid_pkg::NUM_SEG - 1; k++) begin
            vec.push_back(sigmoid_pkg::SEG_BREAK[k]);
            vec.push_back(sigmoid_pkg::SEG_BREAK[k] + 16'sd1);
        end
        vec.push_back(16'sh8000);
        vec.push_back(16'sh7FFF);
        vec.push_back(16'sh0000);
        foreach (vec[i]) begin
            push_sample(vec[i]);
            if (pending == FIFO_DEPTH) begin
                drain_all();
            end
        end
        drain_all();

        // back-to-back writes with no reads, then one write too many
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            x = random_sample();
            apb_write(sigmoid_pkg::ADDR_DATA_IN, {{16{x[15]}}, x}, WAIT_LIMIT, 1'b1, done, rerr);
            assert (done && !rerr) else stop_with_error("back-to-back write was not accepted");
        end
        apb_write(sigmoid_pkg::ADDR_DATA_IN, 32'h0000_0100, 20, 1'b0, done, rerr);
        assert (!done) else stop_with_error("a write completed while the FIFO had no room");
        wait_status(FIFO_DEPTH);
        drain_all();

        // random interleave of writes and pops
        written = 0;
        while (written < RANDOM_COUNT) begin
            if (pending < FIFO_DEPTH && (($urandom % 3) != 0 || pending == 0)) begin
                push_sample(random_sample());
                written++;
            end else begin
                apb_read(sigmoid_pkg::ADDR_DATA_OUT, rdata, rerr);
                if (rerr) begin
                    assert (rdata == 0) else stop_with_error($sformatf(
                        "[FAIL] %0t: errored pop expected 0 got %h", $time, rdata));
                end
            end
        end
        drain_all();

        // unmapped addresses leave the FIFO alone
        push_sample(16'sh0123);
        wait_status(1);
        base_count = 1;
        apb_write(12'h00C, 32'h0000_0055, WAIT_LIMIT, 1'b0, done, rerr);
        assert (done && rerr) else stop_with_error("write to an unmapped address gave no error");
        apb_write(sigmoid_pkg::ADDR_DATA_OUT, 32'h0000_0066, WAIT_LIMIT, 1'b0, done, rerr);
        assert (done && rerr) else stop_with_error("write to the output register gave no error");
        apb_read(12'h010, rdata, rerr);
        assert (rerr && rdata == 0) else stop_with_error($sformatf(
            "[FAIL] %0t: unmapped read expected error and 0, got %h", $time, rdata));
        apb_read(sigmoid_pkg::ADDR_STATUS, rdata, rerr);
        assert (!rerr && rdata == base_count) else stop_with_error($sformatf(
            "[FAIL] %0t: status expected %0d got %0d", $time, base_count, rdata));
        drain_all();

        @(negedge M_AXI_ACLK);
        if (exp_q.size() != 0 || got_q.size() != 0 || compared == 0) begin
            stop_with_error("run ended with written samples never read back");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* project.f */
sigmoid_pkg.sv
sigmoid_segment_lookup.sv
sigmoid_mac.sv
sigmoid_result_fifo.sv
sigmoid_apb_slave.sv
sigmoid_top.sv
tb_sigmoid.sv
